// File: Makefile
VERILATOR  := verilator
TOP        := tb_eth_loop
FILELIST   := filelist.f
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
rtl/eth_loop_pkg.sv
rtl/eth_sc_fifo.sv
rtl/eth_csr_ctrl.sv
rtl/eth_pkt_gen.sv
rtl/eth_xgmii_enc.sv
rtl/eth_xgmii_dec.sv
rtl/eth_pkt_mon.sv
rtl/eth_loop_top.sv
verification/tb_clock_gen.sv
verification/tb_eth_loop.sv

// File: rtl/eth_csr_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module eth_csr_ctrl (
    input  wire                          clk_156_i,
    input  wire                          reset_i,
    input  wire eth_loop_pkg::axil_req_t axil_i,
    output eth_loop_pkg::axil_rsp_t      axil_o,
    output eth_loop_pkg::gen_cfg_t       gen_cfg_o,
    output logic                         mon_enable_o,
    input  wire                          gen_busy_i,
    input  wire                          rx_almost_full_i,
    input  wire                          rx_almost_empty_i,
    input  wire                          good_i,
    input  wire                          bad_i,
    input  wire                          overflow_i
);
    import eth_loop_pkg::*;

    logic        wr_acc;
    logic        rd_acc;
    logic        bvalid_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic        start_q;
    logic        mon_en_q;
    logic [15:0] pkt_count_q;
    logic [4:0]  pkt_len_q;
    mon_cnt_t    cnt_q;

    function automatic logic [4:0] clamp_len(input logic [31:0] len);
        if (len == 32'd0) begin
            return 5'd1;
        end else if (len > MAX_PKT_LEN) begin
            return 5'(MAX_PKT_LEN);
        end
        return len[4:0];
    endfunction

    // One write and one read in flight at most
    assign wr_acc = axil_i.awvalid && axil_i.wvalid && !bvalid_q;
    assign rd_acc = axil_i.arvalid && !rvalid_q;

    always_comb begin
        axil_o         = '0;
        axil_o.awready = wr_acc;
        axil_o.wready  = wr_acc;
        axil_o.bvalid  = bvalid_q;
        axil_o.arready = rd_acc;
        axil_o.rvalid  = rvalid_q;
        axil_o.rdata   = rdata_q;
    end

    assign gen_cfg_o    = '{start: start_q, pkt_count: pkt_count_q, pkt_len: pkt_len_q};
    assign mon_enable_o = mon_en_q;

    always_ff @(posedge clk_156_i) begin
        if (reset_i) begin
            bvalid_q    <= 1'b0;
            start_q     <= 1'b0;
            mon_en_q    <= 1'b0;
            pkt_count_q <= '0;
            pkt_len_q   <= '0;
        end else begin
            start_q <= 1'b0;
            if (wr_acc) begin
                bvalid_q <= 1'b1;
            end else if (axil_i.bready) begin
                bvalid_q <= 1'b0;
            end
            if (wr_acc) begin
                case (axil_i.awaddr)
                    REG_CTRL: if (axil_i.wstrb[0]) begin
                        start_q  <= axil_i.wdata[0];
                        mon_en_q <= axil_i.wdata[1];
                    end
                    REG_PKT_COUNT: begin
                        if (axil_i.wstrb[0]) pkt_count_q[7:0] <= axil_i.wdata[7:0];
                        if (axil_i.wstrb[1]) pkt_count_q[15:8] <= axil_i.wdata[15:8];
                    end
                    REG_PKT_LEN: if (axil_i.wstrb[0]) pkt_len_q <= clamp_len(axil_i.wdata);
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_156_i) begin
        if (reset_i) begin
            rvalid_q <= 1'b0;
        end else if (rd_acc) begin
            rvalid_q <= 1'b1;
        end else if (axil_i.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_156_i) begin
        if (rd_acc) begin
            case (axil_i.araddr)
                REG_CTRL:      rdata_q <= {30'b0, mon_en_q, start_q};
                REG_PKT_COUNT: rdata_q <= {16'b0, pkt_count_q};
                REG_PKT_LEN:   rdata_q <= {27'b0, pkt_len_q};
                REG_STATUS:    rdata_q <= {29'b0, rx_almost_empty_i, rx_almost_full_i, gen_busy_i};
                REG_GOOD:      rdata_q <= cnt_q.good;
                REG_BAD:       rdata_q <= cnt_q.bad;
                REG_DROP:      rdata_q <= cnt_q.drop;
                default:       rdata_q <= '0;
            endcase
        end
    end

    // Event counters from the monitor and the receive FIFO
    always_ff @(posedge clk_156_i) begin
        if (reset_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q.good <= cnt_q.good + 32'(good_i);
            cnt_q.bad  <= cnt_q.bad + 32'(bad_i);
            cnt_q.drop <= cnt_q.drop + 32'(overflow_i);
        end
    end

endmodule

`default_nettype wire

// File: rtl/eth_loop_pkg.sv
`default_nettype none

package eth_loop_pkg;

    localparam int DATA_W          = 64;
    localparam int CTRL_W          = 8;
    localparam int TX_FIFO_DEPTH   = 32;
    localparam int RX_FIFO_DEPTH   = 32;
    localparam int MAX_PKT_LEN     = 16;
    localparam int RX_ALMOST_FULL  = 24;
    localparam int RX_ALMOST_EMPTY = 4;

    localparam logic [7:0] XGMII_IDLE  = 8'h07;
    localparam logic [7:0] XGMII_START = 8'hFB;
    localparam logic [7:0] XGMII_TERM  = 8'hFD;

    localparam logic [7:0] REG_CTRL      = 8'h00;
    localparam logic [7:0] REG_PKT_COUNT = 8'h04;
    localparam logic [7:0] REG_PKT_LEN   = 8'h08;
    localparam logic [7:0] REG_STATUS    = 8'h0C;
    localparam logic [7:0] REG_GOOD      = 8'h10;
    localparam logic [7:0] REG_BAD       = 8'h14;
    localparam logic [7:0] REG_DROP      = 8'h18;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              sop;
        logic              eop;
    } tx_beat_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic              sop;
        logic              eop;
        logic              err;
    } rx_beat_t;

    // Lane k of ctrl qualifies byte k of data
    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [CTRL_W-1:0] ctrl;
    } xgmii_t;

    localparam xgmii_t XGMII_IDLE_WORD  = '{data: {8{XGMII_IDLE}}, ctrl: 8'hFF};
    localparam xgmii_t XGMII_START_WORD = '{data: {{7{8'h55}}, XGMII_START}, ctrl: 8'h01};
    localparam xgmii_t XGMII_TERM_WORD  = '{data: {{7{XGMII_IDLE}}, XGMII_TERM}, ctrl: 8'hFF};

    typedef struct packed {
        logic [7:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
        logic        wvalid;
        logic        bready;
        logic [7:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic        start;
        logic [15:0] pkt_count;
        logic [4:0]  pkt_len;
    } gen_cfg_t;

    typedef struct packed {
        logic [31:0] good;
        logic [31:0] bad;
        logic [31:0] drop;
    } mon_cnt_t;

endpackage

`default_nettype wire

// File: rtl/eth_loop_top.sv
`timescale 1ns/10ps
`default_nettype none

module eth_loop_top (
    input  wire                          clk_156_i,
    input  wire                          reset_i,
    input  wire eth_loop_pkg::axil_req_t axil_i,
    output eth_loop_pkg::axil_rsp_t      axil_o,
    output eth_loop_pkg::xgmii_t         xgmii_tx_o,
    input  wire eth_loop_pkg::xgmii_t    xgmii_rx_i
);
    import eth_loop_pkg::*;

    gen_cfg_t gen_cfg;
    tx_beat_t gen_beat;
    tx_beat_t tx_beat;
    rx_beat_t dec_beat;
    rx_beat_t rx_beat;
    logic     gen_valid;
    logic     gen_ready;
    logic     gen_busy;
    logic     tx_valid;
    logic     enc_ready;
    logic     tx_pkt_avail;
    logic     dec_valid;
    logic     rx_valid;
    logic     mon_ready;
    logic     mon_enable;
    logic     rx_almost_full;
    logic     rx_almost_empty;
    logic     rx_overflow;
    logic     good;
    logic     bad;

    eth_csr_ctrl csr_inst (
        .clk_156_i        (clk_156_i),
        .reset_i          (reset_i),
        .axil_i           (axil_i),
        .axil_o           (axil_o),
        .gen_cfg_o        (gen_cfg),
        .mon_enable_o     (mon_enable),
        .gen_busy_i       (gen_busy),
        .rx_almost_full_i (rx_almost_full),
        .rx_almost_empty_i(rx_almost_empty),
        .good_i           (good),
        .bad_i            (bad),
        .overflow_i       (rx_overflow)
    );

    eth_pkt_gen gen_inst (
        .clk_156_i(clk_156_i),
        .reset_i  (reset_i),
        .cfg_i    (gen_cfg),
        .beat_o   (gen_beat),
        .valid_o  (gen_valid),
        .ready_i  (gen_ready),
        .busy_o   (gen_busy)
    );

    eth_sc_fifo #(
        .beat_t      (tx_beat_t),
        .DEPTH       (TX_FIFO_DEPTH),
        .ALMOST_FULL (TX_FIFO_DEPTH),
        .ALMOST_EMPTY(0)
    ) tx_fifo (
        .clk_156_i     (clk_156_i),
        .reset_i       (reset_i),
        .in_i          (gen_beat),
        .in_valid_i    (gen_valid),
        .in_ready_o    (gen_ready),
        .out_o         (tx_beat),
        .out_valid_o   (tx_valid),
        .out_ready_i   (enc_ready),
        .pkt_avail_o   (tx_pkt_avail),
        .almost_full_o (),
        .almost_empty_o(),
        .overflow_o    ()
    );

    eth_xgmii_enc enc_inst (
        .clk_156_i  (clk_156_i),
        .reset_i    (reset_i),
        .beat_i     (tx_beat),
        .valid_i    (tx_valid),
        .ready_o    (enc_ready),
        .pkt_avail_i(tx_pkt_avail),
        .xgmii_o    (xgmii_tx_o)
    );

    eth_xgmii_dec dec_inst (
        .clk_156_i(clk_156_i),
        .reset_i  (reset_i),
        .xgmii_i  (xgmii_rx_i),
        .beat_o   (dec_beat),
        .valid_o  (dec_valid)
    );

    // The decoder cannot stall, so a full FIFO drops beats
    eth_sc_fifo #(
        .beat_t      (rx_beat_t),
        .DEPTH       (RX_FIFO_DEPTH),
        .ALMOST_FULL (RX_ALMOST_FULL),
        .ALMOST_EMPTY(RX_ALMOST_EMPTY)
    ) rx_fifo (
        .clk_156_i     (clk_156_i),
        .reset_i       (reset_i),
        .in_i          (dec_beat),
        .in_valid_i    (dec_valid),
        .in_ready_o    (),
        .out_o         (rx_beat),
        .out_valid_o   (rx_valid),
        .out_ready_i   (mon_ready),
        .pkt_avail_o   (),
        .almost_full_o (rx_almost_full),
        .almost_empty_o(rx_almost_empty),
        .overflow_o    (rx_overflow)
    );

    eth_pkt_mon mon_inst (
        .clk_156_i(clk_156_i),
        .reset_i  (reset_i),
        .enable_i (mon_enable),
        .beat_i   (rx_beat),
        .valid_i  (rx_valid),
        .ready_o  (mon_ready),
        .good_o   (good),
        .bad_o    (bad)
    );

endmodule

`default_nettype wire

// File: rtl/eth_pkt_gen.sv
`timescale 1ns/10ps
`default_nettype none

module eth_pkt_gen (
    input  wire                         clk_156_i,
    input  wire                         reset_i,
    input  wire eth_loop_pkg::gen_cfg_t cfg_i,
    output eth_loop_pkg::tx_beat_t      beat_o,
    output logic                        valid_o,
    input  wire                         ready_i,
    output logic                        busy_o
);
    logic [31:0] pkt_idx_q;
    logic [15:0] remain_q;
    logic [4:0]  word_q;
    logic [4:0]  len_q;
    logic        busy_q;
    logic        last_word;

    assign last_word   = (word_q == len_q - 5'd1);
    assign beat_o.data = {pkt_idx_q, 27'b0, word_q};
    assign beat_o.sop  = (word_q == 5'd0);
    assign beat_o.eop  = last_word;
    assign valid_o     = busy_q;
    assign busy_o      = busy_q;

    // Packet index runs on across starts so the monitor stays in step
    always_ff @(posedge clk_156_i) begin
        if (reset_i) begin
            busy_q    <= 1'b0;
            pkt_idx_q <= '0;
            remain_q  <= '0;
            word_q    <= '0;
        end else if (!busy_q) begin
            if (cfg_i.start && cfg_i.pkt_count != 16'd0) begin
                busy_q   <= 1'b1;
                remain_q <= cfg_i.pkt_count;
                len_q    <= cfg_i.pkt_len;
                word_q   <= '0;
            end
        end else if (ready_i) begin
            if (last_word) begin
                word_q    <= '0;
                pkt_idx_q <= pkt_idx_q + 32'd1;
                remain_q  <= remain_q - 16'd1;
                busy_q    <= (remain_q != 16'd1);
            end else begin
                word_q <= word_q + 5'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/eth_pkt_mon.sv
`timescale 1ns/10ps
`default_nettype none

module eth_pkt_mon (
    input  wire                         clk_156_i,
    input  wire                         reset_i,
    input  wire                         enable_i,
    input  wire eth_loop_pkg::rx_beat_t beat_i,
    input  wire                         valid_i,
    output logic                        ready_o,
    output logic                        good_o,
    output logic                        bad_o
);
    logic [31:0] exp_pkt_q;
    logic [31:0] exp_word_q;
    logic        bad_seen_q;
    logic        take;
    logic        mismatch;

    assign ready_o  = enable_i;
    assign take     = valid_i && enable_i;
    // Same pattern as the generator, packet index high and word index low
    assign mismatch = beat_i.err || (beat_i.data != {exp_pkt_q, exp_word_q}) ||
                      (beat_i.sop != (exp_word_q == 32'd0));

    always_ff @(posedge clk_156_i) begin
        if (reset_i) begin
            exp_pkt_q  <= '0;
            exp_word_q <= '0;
            bad_seen_q <= 1'b0;
            good_o     <= 1'b0;
            bad_o      <= 1'b0;
        end else begin
            good_o <= 1'b0;
            bad_o  <= 1'b0;
            if (take && beat_i.eop) begin
                good_o     <= !(bad_seen_q || mismatch);
                bad_o      <= bad_seen_q || mismatch;
                exp_pkt_q  <= exp_pkt_q + 32'd1;
                exp_word_q <= '0;
                bad_seen_q <= 1'b0;
            end else if (take) begin
                exp_word_q <= exp_word_q + 32'd1;
                bad_seen_q <= bad_seen_q || mismatch;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/eth_sc_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module eth_sc_fifo #(
    parameter type beat_t       = eth_loop_pkg::tx_beat_t,
    parameter int  DEPTH        = 32,
    parameter int  ALMOST_FULL  = 24,
    parameter int  ALMOST_EMPTY = 4
) (
    input  wire        clk_156_i,
    input  wire        reset_i,
    input  wire beat_t in_i,
    input  wire        in_valid_i,
    output logic       in_ready_o,
    output beat_t      out_o,
    output logic       out_valid_o,
    input  wire        out_ready_i,
    output logic       pkt_avail_o,
    output logic       almost_full_o,
    output logic       almost_empty_o,
    output logic       overflow_o
);
    localparam int AW = $clog2(DEPTH);
    localparam int CW = $clog2(DEPTH + 1);

    beat_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr_q;
    logic [AW-1:0] rd_ptr_q;
    logic [CW-1:0] fill_q;
    logic [CW-1:0] pkts_q;
    logic          push;
    logic          pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        return (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign in_ready_o     = (fill_q != CW'(DEPTH));
    assign push           = in_valid_i && in_ready_o;
    assign pop            = out_valid_o && out_ready_i;
    assign out_o          = mem[rd_ptr_q];
    assign out_valid_o    = (fill_q != '0);
    assign pkt_avail_o    = (pkts_q != '0);
    assign almost_full_o  = (fill_q >= CW'(ALMOST_FULL));
    assign almost_empty_o = (fill_q <= CW'(ALMOST_EMPTY));
    assign overflow_o     = in_valid_i && !in_ready_o;

    always_ff @(posedge clk_156_i) begin
        if (push) begin
            mem[wr_ptr_q] <= in_i;
        end
    end

    // Complete packets are counted on their eop beats
    always_ff @(posedge clk_156_i) begin
        if (reset_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            fill_q   <= '0;
            pkts_q   <= '0;
        end else begin
            if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
            if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
            fill_q <= fill_q + CW'(push) - CW'(pop);
            pkts_q <= pkts_q + CW'(push && in_i.eop) - CW'(pop && out_o.eop);
        end
    end

endmodule

`default_nettype wire

// File: rtl/eth_xgmii_dec.sv
`timescale 1ns/10ps
`default_nettype none

module eth_xgmii_dec (
    input  wire                       clk_156_i,
    input  wire                       reset_i,
    input  wire eth_loop_pkg::xgmii_t xgmii_i,
    output eth_loop_pkg::rx_beat_t    beat_o,
    output logic                      valid_o
);
    import eth_loop_pkg::*;

    logic              in_pkt_q;
    logic              first_q;
    logic              buf_valid_q;
    logic [DATA_W-1:0] buf_data_q;
    logic              buf_sop_q;
    logic              is_ctrl;
    logic              is_start;
    logic              is_term;

    assign is_ctrl  = (xgmii_i.ctrl != '0);
    assign is_start = xgmii_i.ctrl[0] && (xgmii_i.data[7:0] == XGMII_START);
    assign is_term  = xgmii_i.ctrl[0] && (xgmii_i.data[7:0] == XGMII_TERM);

    always_ff @(posedge clk_156_i) begin
        if (reset_i) begin
            in_pkt_q    <= 1'b0;
            first_q     <= 1'b0;
            buf_valid_q <= 1'b0;
            valid_o     <= 1'b0;
        end else begin
            valid_o <= 1'b0;
            if (!in_pkt_q) begin
                in_pkt_q    <= is_start;
                first_q     <= 1'b1;
                buf_valid_q <= 1'b0;
            end else if (!is_ctrl) begin
                // Hold each word until the next one shows whether it was the last
                valid_o     <= buf_valid_q;
                beat_o      <= '{data: buf_data_q, sop: buf_sop_q, eop: 1'b0, err: 1'b0};
                buf_data_q  <= xgmii_i.data;
                buf_sop_q   <= first_q;
                buf_valid_q <= 1'b1;
                first_q     <= 1'b0;
            end else begin
                // Terminate closes cleanly, any other control character with err
                in_pkt_q    <= 1'b0;
                buf_valid_q <= 1'b0;
                valid_o     <= buf_valid_q || !is_term;
                beat_o.data <= buf_valid_q ? buf_data_q : xgmii_i.data;
                beat_o.sop  <= buf_valid_q ? buf_sop_q : 1'b1;
                beat_o.eop  <= 1'b1;
                beat_o.err  <= !is_term;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/eth_xgmii_enc.sv
`timescale 1ns/10ps
`default_nettype none

module eth_xgmii_enc (
    input  wire                         clk_156_i,
    input  wire                         reset_i,
    input  wire eth_loop_pkg::tx_beat_t beat_i,
    input  wire                         valid_i,
    output logic                        ready_o,
    input  wire                         pkt_avail_i,
    output eth_loop_pkg::xgmii_t        xgmii_o
);
    import eth_loop_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_TERM
    } state_t;

    state_t state_q;

    // Data words are popped straight into the output register
    assign ready_o = (state_q == ST_DATA);

    always_ff @(posedge clk_156_i) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            xgmii_o <= XGMII_IDLE_WORD;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    xgmii_o <= XGMII_IDLE_WORD;
                    if (pkt_avail_i) state_q <= ST_START;
                end
                ST_START: begin
                    xgmii_o <= XGMII_START_WORD;
                    state_q <= ST_DATA;
                end
                ST_DATA: begin
                    if (valid_i) begin
                        xgmii_o <= '{data: beat_i.data, ctrl: '0};
                        if (beat_i.eop) state_q <= ST_TERM;
                    end else begin
                        xgmii_o <= XGMII_IDLE_WORD;
                    end
                end
                default: begin
                    xgmii_o <= XGMII_TERM_WORD;
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verification/eth_loop_trace.txt
# Columns: command, register offset (hex), value (hex), poll limit in cycles (decimal)
# W write, R read and compare, P poll until equal, X corrupt next packet, E end
R 00 00000000
R 04 00000000
R 08 00000000
R 0C 00000004
R 10 00000000
R 14 00000000
R 18 00000000
W 08 00000000
R 08 00000001
W 08 00000028
R 08 00000010
W 10 00000005
R 10 00000000
W 04 00000003
W 08 00000005
W 00 00000003
P 10 00000003 400
R 14 00000000
P 0C 00000004 100
R 00 00000002
W 04 00000002
X
W 00 00000003
P 10 00000004 400
R 14 00000001
W 04 00000004
W 08 00000010
W 00 00000001
P 18 00000020 1000
P 0C 00000002 200
R 10 00000004
E

// File: verification/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk_o
);
    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

endmodule

`default_nettype wire

// File: verification/tb_eth_loop.sv
`timescale 1ns/10ps
`default_nettype none

module tb_eth_loop;
    import eth_loop_pkg::*;

    localparam string TRACE_FILE      = "verification/eth_loop_trace.txt";
    localparam int    HS_LIMIT        = 50;
    localparam int    WATCHDOG_CYCLES = 20000;
    localparam int    TX_IDLE         = 0;
    localparam int    TX_DATA         = 1;
    localparam int    TX_GAP          = 2;

    logic      clk_156;
    logic      reset;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;
    axil_rsp_t rsp_snap;
    xgmii_t    dut_tx;
    xgmii_t    xgmii_rx;
    xgmii_t    rx_word;
    int        value_errs   = 0;
    int        flow_errs    = 0;
    int        cycle_cnt    = 0;
    logic      corrupt_next = 1'b0;
    logic      after_start  = 1'b0;
    int        tx_state     = TX_IDLE;
    int        tx_pkt       = 0;
    int        tx_word      = 0;
    int        exp_len      = 0;
    int        last_count   = 0;
    int        exp_pkts     = 0;

    tb_clock_gen #(.PERIOD_NS(8)) clk_gen (.clk_o(clk_156));

    eth_loop_top dut0 (
        .clk_156_i (clk_156),
        .reset_i   (reset),
        .axil_i    (axil_req),
        .axil_o    (axil_rsp),
        .xgmii_tx_o(dut_tx),
        .xgmii_rx_i(xgmii_rx)
    );

    always @(posedge clk_156) cycle_cnt <= cycle_cnt + 1;

    function automatic logic is_idle_word(input xgmii_t w);
        return w.ctrl == 8'hFF && w.data == 64'h0707070707070707;
    endfunction

    function automatic logic is_start_word(input xgmii_t w);
        return w.ctrl == 8'h01 && w.data == 64'h55555555555555FB;
    endfunction

    function automatic logic is_term_word(input xgmii_t w);
        return w.ctrl == 8'hFF && w.data == 64'h07070707070707FD;
    endfunction

    // Length register saturates at both ends
    function automatic int expected_pkt_len(input logic [31:0] val);
        if (val == 0) return 1;
        if (val > MAX_PKT_LEN) return MAX_PKT_LEN;
        return int'(val);
    endfunction

    function automatic logic rsp_flag(input int sel);
        case (sel)
            0: return axil_rsp.awready;
            1: return axil_rsp.bvalid;
            2: return axil_rsp.arready;
            default: return axil_rsp.rvalid;
        endcase
    endfunction

    task automatic note_mismatch(input string msg);
        value_errs++;
        $display("FAIL @%0t: %s", $time, msg);
    endtask

    task automatic finish_run();
        $display("Errors: %0d value, %0d timeout or trace", value_errs, flow_errs);
        if (value_errs == 0 && flow_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    // Returns 1 ns after the clock edge that completed the handshake
    task automatic await_flag(input int sel, input string what);
        int   n;
        logic seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < HS_LIMIT) begin
            @(negedge clk_156);
            seen = rsp_flag(sel);
            rsp_snap = axil_rsp;
            @(posedge clk_156);
            n++;
        end
        #1;
        if (!seen) begin
            flow_errs++;
            $display("Timeout at %0t: the DUT never raised %s", $time, what);
        end
    endtask

    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
        axil_req.awaddr  = addr;
        axil_req.wdata   = data;
        axil_req.wstrb   = 4'hF;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        axil_req.bready  = 1'b1;
        await_flag(0, "awready");
        assert (rsp_snap.wready)
        else note_mismatch($sformatf("write to 0x%02h had awready without wready", addr));
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        await_flag(1, "bvalid");
        axil_req.bready = 1'b0;
        assert (rsp_snap.bresp == 2'b00)
        else note_mismatch($sformatf("write to 0x%02h not OKAY", addr));
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
        axil_req.araddr  = addr;
        axil_req.arvalid = 1'b1;
        axil_req.rready  = 1'b1;
        await_flag(2, "arready");
        axil_req.arvalid = 1'b0;
        await_flag(3, "rvalid");
        axil_req.rready = 1'b0;
        data = rsp_snap.rdata;
        assert (rsp_snap.rresp == 2'b00)
        else note_mismatch($sformatf("read of 0x%02h not OKAY", addr));
    endtask

    task automatic poll_reg(input logic [7:0] addr, input logic [31:0] exp, input int limit);
        int          start;
        logic [31:0] val;
        logic        hit;
        start = cycle_cnt;
        hit = 1'b0;
        while (!hit && cycle_cnt - start < limit) begin
            axil_read(addr, val);
            hit = (val === exp);
        end
        if (!hit) begin
            flow_errs++;
            $display("Timeout at %0t: register 0x%02h never reached 0x%08h in %0d cycles",
                     $time, addr, exp, limit);
        end
    endtask

    // Expected packet shape follows every write seen in the trace
    task automatic track_write(input logic [7:0] addr, input logic [31:0] data);
        if (addr == REG_PKT_LEN) exp_len = expected_pkt_len(data);
        if (addr == REG_PKT_COUNT) last_count = int'(data[15:0]);
        if (addr == REG_CTRL && data[0]) exp_pkts += last_count;
    endtask

    task automatic run_trace(input int fd);
        logic [63:0]   tok;
        logic [7:0]    addr;
        logic [31:0]   data;
        logic [31:0]   val;
        logic [1023:0] rest;
        int            limit;
        int            code;
        logic          done;
        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, "%s", tok);
            if (code != 1) begin
                flow_errs++;
                $display("Trace file ended without an E command");
                done = 1'b1;
            end else begin
                case (tok[7:0])
                    "#": code = $fgets(rest, fd);
                    "W": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        track_write(addr, data);
                        axil_write(addr, data);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", addr, data);
                        axil_read(addr, val);
                        assert (val === data)
                        else note_mismatch($sformatf("register 0x%02h read 0x%08h, expected 0x%08h",
                                                     addr, val, data));
                    end
                    "P": begin
                        code = $fscanf(fd, "%h %h %d", addr, data, limit);
                        poll_reg(addr, data, limit);
                    end
                    "X": corrupt_next = 1'b1;
                    "E": begin
                        assert (tx_pkt == exp_pkts)
                        else note_mismatch($sformatf("%0d packets sent on XGMII, expected %0d",
                                                     tx_pkt, exp_pkts));
                        done = 1'b1;
                    end
                    default: begin
                        flow_errs++;
                        $display("Unknown command in trace file");
                        done = 1'b1;
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    // Transmit lanes loop back to receive, with an optional bad control bit
    always @(posedge clk_156) begin
        #1;
        rx_word = dut_tx;
        if (corrupt_next && after_start) begin
            rx_word.ctrl[3] = 1'b1;
            corrupt_next = 1'b0;
        end
        after_start = is_start_word(dut_tx);
        xgmii_rx = rx_word;
    end

    // Independent decoder of the transmit lanes
    always @(negedge clk_156) begin
        if (!reset) begin
            case (tx_state)
                TX_IDLE: begin
                    if (is_start_word(dut_tx)) begin
                        tx_state = TX_DATA;
                        tx_word = 0;
                    end else begin
                        assert (is_idle_word(dut_tx))
                        else note_mismatch("non-idle word outside a packet");
                    end
                end
                TX_DATA: begin
                    if (dut_tx.ctrl == 8'h00) begin
                        assert (dut_tx.data == {tx_pkt, tx_word})
                        else note_mismatch($sformatf("packet %0d word %0d carried 0x%016h",
                                                     tx_pkt, tx_word, dut_tx.data));
                        tx_word++;
                    end else if (is_term_word(dut_tx)) begin
                        assert (tx_word == exp_len)
                        else note_mismatch($sformatf("packet %0d had %0d words, expected %0d",
                                                     tx_pkt, tx_word, exp_len));
                        tx_pkt++;
                        tx_state = TX_GAP;
                    end else begin
                        note_mismatch("control word inside a packet");
                        tx_state = TX_IDLE;
                    end
                end
                default: begin
                    assert (is_idle_word(dut_tx))
                    else note_mismatch("no idle word after terminate");
                    tx_state = TX_IDLE;
                end
            endcase
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_156);
        flow_errs++;
        $display("Timeout: the trace did not finish within %0d cycles", WATCHDOG_CYCLES);
        finish_run();
    end

    initial begin
        int fd;
        reset = 1'b1;
        axil_req = '0;
        xgmii_rx = '{data: 64'h0707070707070707, ctrl: 8'hFF};
        repeat (2) @(posedge clk_156);
        #1;
        reset = 1'b0;
        fd = $fopen(TRACE_FILE, "r");
        if (fd == 0) begin
            flow_errs++;
            $display("Cannot open trace file %s", TRACE_FILE);
        end else begin
            run_trace(fd);
        end
        finish_run();
    end

endmodule

`default_nettype wire
